// ==== build.f ====
+incdir+include
src/scc_pkg.sv
src/scc_phase_decode.sv
src/scc_avl_slave.sv
src/scc_cfg_regs.sv
src/scc_shift_engine.sv
src/scc_mgr.sv
test/scc_mgr_properties.sv
test/scc_mgr_tb.sv

// ==== Bender.yml ====
package:
  name: scc_mgr

export_include_dirs:
  - include

sources:
  - files:
      - src/scc_pkg.sv
      - src/scc_phase_decode.sv
      - src/scc_avl_slave.sv
      - src/scc_cfg_regs.sv
      - src/scc_shift_engine.sv
      - src/scc_mgr.sv
  - target: test
    files:
      - test/scc_mgr_properties.sv
      - test/scc_mgr_tb.sv

// ==== test/scc_mgr_tb.sv ====
/*
 * Testbench for the scan-chain configuration manager
 * Clock, reset, LFSR stimulus, Avalon bus tasks, scan monitor,
 * immediate checks against a model of the scan words and the result line
 */
`timescale 1ns/1ps
`default_nettype none
`include "scc_config.svh"

module scc_mgr_tb
	import scc_pkg::*;
;

	localparam int MAX_CYCLES = 2 * 20 * 50; // 20 transactions of up to 50 cycles, doubled

	logic                           avl_clk;
	logic                           avl_reset_n;
	logic [`SCC_AVL_ADDR_WIDTH-1:0] avl_address;
	logic                           avl_write;
	logic [`SCC_AVL_DATA_WIDTH-1:0] avl_writedata;
	logic                           avl_read;
	logic [`SCC_AVL_DATA_WIDTH-1:0] avl_readdata;
	logic                           avl_waitrequest;
	logic                           scc_data;
	logic [`SCC_DQS_GROUPS-1:0]     scc_dqs_ena;
	logic [`SCC_DQS_GROUPS-1:0]     scc_dqs_io_ena;
	logic [`SCC_DQ_PINS-1:0]        scc_dq_ena;
	logic [`SCC_DM_PINS-1:0]        scc_dm_ena;
	logic                           scc_upd;

	int          cycles = 0;
	int          errors = 0;
	logic [15:0] lfsr_state = 16'd86;

	// Scan monitor state
	logic [21:0] ena_now;    // {dqs, dqs_io, dq, dm}
	logic [21:0] first_ena;
	logic [45:0] stream;
	logic        ena_changed;
	int          ena_cycles, upd_cycles, first_cyc, last_cyc;

	scc_mgr UUT (
		.avl_clk         (avl_clk),
		.avl_reset_n     (avl_reset_n),
		.avl_address     (avl_address),
		.avl_write       (avl_write),
		.avl_writedata   (avl_writedata),
		.avl_read        (avl_read),
		.avl_readdata    (avl_readdata),
		.avl_waitrequest (avl_waitrequest),
		.scc_data        (scc_data),
		.scc_dqs_ena     (scc_dqs_ena),
		.scc_dqs_io_ena  (scc_dqs_io_ena),
		.scc_dq_ena      (scc_dq_ena),
		.scc_dm_ena      (scc_dm_ena),
		.scc_upd         (scc_upd)
	);

	initial
	begin
		avl_clk = 1'b0;
		forever #10 avl_clk = ~avl_clk;
	end

	always @(posedge avl_clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	assign ena_now = {scc_dqs_ena, scc_dqs_io_ena, scc_dq_ena, scc_dm_ena};

	// Outputs change on the rising edge, so sample in the middle of the cycle
	always @(negedge avl_clk)
	begin
		if (ena_now != '0)
		begin
			if (ena_cycles == 0)
			begin
				first_ena = ena_now;
				first_cyc = cycles;
			end
			else if (ena_now !== first_ena)
				ena_changed = 1'b1;
			last_cyc   = cycles;
			ena_cycles = ena_cycles + 1;
			stream     = {stream[44:0], scc_data}; // First bit ends up on top
		end
		if (scc_upd)
			upd_cycles = upd_cycles + 1;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v          = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Expected DQS word, laid out bit by bit in scan order
	function automatic logic [45:0] dqs_word(input logic [6:0] dqs, input logic [6:0] dq,
		input logic [5:0] dqse, input logic [3:0] in_dly, input logic [2:0] en_dly,
		input logic [3:0] oct1, input logic [2:0] oct2);
		logic [45:0] w;
		w        = '0;
		w[45]    = dqs[2];
		w[44]    = dq[2];
		w[43]    = dqse[1];
		w[40]    = dq[1];
		w[39]    = dqs[1];
		w[38]    = dqse[0];
		w[36:34] = oct2;
		w[33:30] = oct1;
		w[29:27] = en_dly;
		w[26]    = dq[0];
		w[24]    = dqs[0];
		w[18:15] = dq[6:3];
		w[14:11] = dqs[6:3];
		w[10:7]  = dqse[5:2];
		w[6:4]   = 3'b001; // DQS-in at 90 deg
		w[3:0]   = in_dly;
		return w;
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act)
		else
		begin
			$display("mismatch %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond)
		else
		begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge avl_clk);
		#2;
	endtask

	// Holds the write until waitrequest falls and counts the stalled cycles
	task automatic bus_write(input logic [2:0] op, input logic [3:0] low,
		input logic [31:0] data, output int waits);
		avl_address   = {3'b011, op, 6'd0, low};
		avl_writedata = data;
		avl_write     = 1'b1;
		waits         = 0;
		@(negedge avl_clk);
		while (avl_waitrequest)
		begin
			waits++;
			@(negedge avl_clk);
		end
		@(posedge avl_clk);
		#2;
		avl_write = 1'b0;
	endtask

	task automatic set_field(input scc_field_e fld, input logic [31:0] data);
		int waits;
		bus_write(SDATA, fld, data, waits);
		check_val({"sdata write stall ", fld.name()}, 0, waits);
	endtask

	task automatic read_param(input scc_param_e code, input logic [31:0] exp);
		avl_address = {3'b011, 3'b000, 6'd0, code};
		avl_read    = 1'b1;
		@(negedge avl_clk);
		check_true(!avl_waitrequest, "a parameter read was stalled by waitrequest");
		check_val({"read ", code.name()}, exp, avl_readdata);
		@(posedge avl_clk);
		#2;
		avl_read = 1'b0;
	endtask

	task automatic go_scan(input logic [2:0] op, input logic [31:0] data, output int waits);
		ena_cycles  = 0;
		upd_cycles  = 0;
		ena_changed = 1'b0;
		stream      = '0;
		bus_write(op, 4'd0, data, waits);
		idle(2); // Let the last registered bit through
	endtask

	task automatic check_scan(input string name, input int waits, input int n,
		input logic [21:0] exp_ena, input logic [45:0] exp_word);
		check_val({name, " waitrequest cycles"}, n + 1, waits);
		check_val({name, " enable cycles"}, n, ena_cycles);
		check_val({name, " enable vector"}, exp_ena, first_ena);
		check_true(!ena_changed && (last_cyc - first_cyc + 1 == ena_cycles),
			{name, ": enables were not steady over consecutive cycles"});
		check_val({name, " stream"}, exp_word, stream);
		check_val({name, " update strobes"}, 0, upd_cycles);
	endtask

	initial
	begin
		int          waits;
		int          prop_fails;
		logic [31:0] io_in, io_out2, io_out1, pin;
		logic [31:0] in_dly, en_dly, oct1, oct2;
		logic [10:0] io_word;

		avl_reset_n   = 1'b0;
		avl_address   = '0;
		avl_write     = 1'b0;
		avl_writedata = '0;
		avl_read      = 1'b0;
		repeat (4) @(posedge avl_clk);
		#2;
		avl_reset_n = 1'b1;

		// Outputs after reset and parameter read-back
		@(negedge avl_clk);
		check_val("reset waitrequest", 0, avl_waitrequest);
		check_val("reset scc_data", 0, scc_data);
		check_val("reset enables", 0, ena_now);
		check_val("reset scc_upd", 0, scc_upd);
		idle(1);
		read_param(PAR_DQS_IN_DELAY_MAX, 15);
		read_param(PAR_DQS_EN_PHASE_MAX, 7);
		read_param(PAR_DQS_EN_DELAY_MAX, 7);
		read_param(PAR_DQDQS_OUT_PHASE_MAX, 14);
		read_param(PAR_IO_OUT1_DELAY_MAX, 15);
		read_param(PAR_IO_OUT2_DELAY_MAX, 7);
		read_param(PAR_IO_IN_DELAY_MAX, 15);
		read_param(PAR_DLL_CHAIN_LENGTH, 8);
		read_param(PAR_DELAY_PER_OPA_TAP, 312);
		read_param(PAR_DELAY_PER_DCHAIN_TAP, 25);
		read_param(PAR_DQS_IN_RESERVE, 3);
		read_param(PAR_DQS_OUT_RESERVE, 3);
		read_param(PAR_DQ_OUT_RESERVE, 0);
		read_param(PAR_DM_OUT_RESERVE, 0);

		// I/O word into one random DQ pin
		take_bits(4, io_in);
		take_bits(3, io_out2);
		take_bits(4, io_out1);
		take_bits(4, pin);
		set_field(IO_IN_DELAY, io_in);
		set_field(IO_OUT2_DELAY, io_out2);
		set_field(IO_OUT1_DELAY, io_out1);
		io_word = {io_in[3:0], io_out2[2:0], io_out1[3:0]};
		go_scan(GO_DQ, pin, waits);
		check_scan("go_dq", waits, 11, {4'b0000, 16'(1) << pin[3:0], 2'b00}, io_word);

		// Power-up DQS word into every group
		go_scan(GO_DQS, 32'hFF, waits);
		check_scan("go_dqs_all", waits, 46, {2'b11, 20'd0},
			dqs_word(7'b0010101, 7'b0000110, 6'b001010, 4'd0, 3'd0, 4'd0, 3'd0));

		// Random DQS delays with the index-0 phase codes
		take_bits(4, in_dly);
		take_bits(3, en_dly);
		take_bits(4, oct1);
		take_bits(3, oct2);
		set_field(DQS_IN_DELAY, in_dly);
		set_field(DQS_EN_DELAY, en_dly);
		set_field(OCT_OUT1_DELAY, oct1);
		set_field(OCT_OUT2_DELAY, oct2);
		set_field(DQDQS_OUT_PHASE, 0);
		set_field(DQS_EN_PHASE, 0);
		go_scan(GO_DQS_IO, 1, waits);
		check_scan("go_dqs_io", waits, 11, {2'b00, 2'b10, 18'd0}, io_word);
		go_scan(GO_DQS, 0, waits);
		check_scan("go_dqs_grp0", waits, 46, {2'b01, 20'd0},
			dqs_word(7'b0010100, 7'b0000100, 6'b001000, in_dly[3:0], en_dly[2:0],
				oct1[3:0], oct2[2:0]));

		// Update strobe, then a DM scan to a group that does not exist
		go_scan(GO_UPD, 0, waits);
		check_val("go_upd waitrequest cycles", 1, waits);
		check_val("go_upd update strobes", 1, upd_cycles);
		check_val("go_upd enable cycles", 0, ena_cycles);
		go_scan(GO_DM, 5, waits);
		check_val("go_dm_out_of_range waitrequest cycles", 12, waits);
		check_val("go_dm_out_of_range enable cycles", 0, ena_cycles);

		idle(2);
		prop_fails = UUT.u_props.wait_fails + UUT.u_props.shape_fails +
			UUT.u_props.overlap_fails + UUT.u_props.window_fails;
		$display("check errors: %0d, property failures: %0d", errors, prop_fails);
		if (errors == 0 && prop_fails == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/scc_mgr_properties.sv ====
/*
 * Concurrent checks on the scan-chain manager outputs
 * Waitrequest only on GO writes, enable vector shape,
 * update strobe apart from enables, enables inside the stall window
 */
`timescale 1ns/1ps
`default_nettype none
`include "scc_config.svh"

module scc_mgr_properties
	import scc_pkg::*;
(
	input logic                           avl_clk,
	input logic                           avl_reset_n,
	input logic [`SCC_AVL_ADDR_WIDTH-1:0] avl_address,
	input logic                           avl_write,
	input logic                           avl_waitrequest,
	input logic [`SCC_DQS_GROUPS-1:0]     scc_dqs_ena,
	input logic [`SCC_DQS_GROUPS-1:0]     scc_dqs_io_ena,
	input logic [`SCC_DQ_PINS-1:0]        scc_dq_ena,
	input logic [`SCC_DM_PINS-1:0]        scc_dm_ena,
	input logic                           scc_upd
);

	int   wait_fails    = 0;
	int   shape_fails   = 0;
	int   overlap_fails = 0;
	int   window_fails  = 0;
	logic go_write;
	logic any_ena;

	assign go_write = avl_write && (avl_address[15:13] == 3'b011) &&
		(scc_target_e'(avl_address[12:10]) != SDATA);
	assign any_ena  = |{scc_dqs_ena, scc_dqs_io_ena, scc_dq_ena, scc_dm_ena};

	wait_on_go: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		avl_waitrequest |-> go_write)
	else
	begin
		$error("waitrequest high outside a GO write");
		wait_fails++;
	end

	// None, one line, or the whole target
	ena_shape: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		($onehot0(scc_dqs_ena) || &scc_dqs_ena) &&
		($onehot0(scc_dqs_io_ena) || &scc_dqs_io_ena) &&
		($onehot0(scc_dq_ena) || &scc_dq_ena) &&
		($onehot0(scc_dm_ena) || &scc_dm_ena))
	else
	begin
		$error("enable vector neither zero, one-hot nor all ones");
		shape_fails++;
	end

	upd_apart: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		scc_upd |-> !any_ena)
	else
	begin
		$error("update strobe together with an enable");
		overlap_fails++;
	end

	// Registered enables trail the stall by one cycle
	ena_in_stall: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		any_ena |-> $past(avl_waitrequest))
	else
	begin
		$error("enable active outside the waitrequest window");
		window_fails++;
	end

endmodule

bind scc_mgr scc_mgr_properties u_props (
	.avl_clk         (avl_clk),
	.avl_reset_n     (avl_reset_n),
	.avl_address     (avl_address),
	.avl_write       (avl_write),
	.avl_waitrequest (avl_waitrequest),
	.scc_dqs_ena     (scc_dqs_ena),
	.scc_dqs_io_ena  (scc_dqs_io_ena),
	.scc_dq_ena      (scc_dq_ena),
	.scc_dm_ena      (scc_dm_ena),
	.scc_upd         (scc_upd)
);

`default_nettype wire

// ==== src/scc_mgr.sv ====
/*
 * Top level of the scan-chain configuration manager
 * Avalon slave, staged words, phase table and scan engine
 */
`timescale 1ns/1ps
`default_nettype none
`include "scc_config.svh"

module scc_mgr
	import scc_pkg::*;
(
	input  logic                           avl_clk,
	input  logic                           avl_reset_n,
	input  logic [`SCC_AVL_ADDR_WIDTH-1:0] avl_address,
	input  logic                           avl_write,
	input  logic [`SCC_AVL_DATA_WIDTH-1:0] avl_writedata,
	input  logic                           avl_read,
	output logic [`SCC_AVL_DATA_WIDTH-1:0] avl_readdata,
	output logic                           avl_waitrequest,
	output logic                           scc_data,
	output logic [`SCC_DQS_GROUPS-1:0]     scc_dqs_ena,
	output logic [`SCC_DQS_GROUPS-1:0]     scc_dqs_io_ena,
	output logic [`SCC_DQ_PINS-1:0]        scc_dq_ena,
	output logic [`SCC_DM_PINS-1:0]        scc_dm_ena,
	output logic                           scc_upd
);

	scc_go_t      go;
	logic         sdata_wr;
	scc_field_e   field;
	logic         scan_done;
	scc_phase_t   phase, phase_reset;
	logic [2:0]   dqsi_phase;
	scc_dqs_cfg_t dqs_cfg;
	scc_io_cfg_t  io_cfg;

	scc_avl_slave u_slave (
		.avl_clk         (avl_clk),
		.avl_reset_n     (avl_reset_n),
		.avl_address     (avl_address),
		.avl_write       (avl_write),
		.avl_read        (avl_read),
		.avl_readdata    (avl_readdata),
		.avl_waitrequest (avl_waitrequest),
		.scan_done       (scan_done),
		.go              (go),
		.sdata_wr        (sdata_wr),
		.field           (field)
	);

	// Phase writes carry the table index in the low data bits
	scc_phase_decode u_phase (
		.phase_index (avl_writedata[4:0]),
		.phase       (phase),
		.phase_reset (phase_reset),
		.dqsi_phase  (dqsi_phase)
	);

	scc_cfg_regs u_cfg (
		.avl_clk       (avl_clk),
		.avl_reset_n   (avl_reset_n),
		.sdata_wr      (sdata_wr),
		.field         (field),
		.avl_writedata (avl_writedata),
		.phase         (phase),
		.phase_reset   (phase_reset),
		.dqsi_phase    (dqsi_phase),
		.dqs_cfg       (dqs_cfg),
		.io_cfg        (io_cfg)
	);

	scc_shift_engine u_engine (
		.avl_clk        (avl_clk),
		.avl_reset_n    (avl_reset_n),
		.go             (go),
		.group_sel      (avl_writedata[7:0]), // Group index held by the master
		.dqs_cfg        (dqs_cfg),
		.io_cfg         (io_cfg),
		.scan_done      (scan_done),
		.scc_data       (scc_data),
		.scc_dqs_ena    (scc_dqs_ena),
		.scc_dqs_io_ena (scc_dqs_io_ena),
		.scc_dq_ena     (scc_dq_ena),
		.scc_dm_ena     (scc_dm_ena),
		.scc_upd        (scc_upd)
	);

endmodule

`default_nettype wire

// ==== src/scc_shift_engine.sv ====
/*
 * Scan engine of the scan-chain manager
 * IDLE/LOAD/DONE FSM, serial shifter, group enable decode and update strobe
 */
`timescale 1ns/1ps
`default_nettype none
`include "scc_config.svh"

module scc_shift_engine
	import scc_pkg::*;
(
	input  logic                       avl_clk,
	input  logic                       avl_reset_n,
	input  scc_go_t                    go,
	input  logic [7:0]                 group_sel,
	input  scc_dqs_cfg_t               dqs_cfg,
	input  scc_io_cfg_t                io_cfg,
	output logic                       scan_done,
	output logic                       scc_data,
	output logic [`SCC_DQS_GROUPS-1:0] scc_dqs_ena,
	output logic [`SCC_DQS_GROUPS-1:0] scc_dqs_io_ena,
	output logic [`SCC_DQ_PINS-1:0]    scc_dq_ena,
	output logic [`SCC_DM_PINS-1:0]    scc_dm_ena,
	output logic                       scc_upd
);

	localparam int DQS_N  = `SCC_DQS_SDATA_BITS;
	localparam int IO_N   = `SCC_IO_SDATA_BITS;
	localparam int CNT_W  = $clog2(DQS_N);
	localparam int ENA_W0 = (`SCC_DQ_PINS > `SCC_DM_PINS) ? `SCC_DQ_PINS : `SCC_DM_PINS;
	localparam int ENA_W  = (ENA_W0 > `SCC_DQS_GROUPS) ? ENA_W0 : `SCC_DQS_GROUPS;

	scc_state_e                 state, state_next;
	logic [CNT_W-1:0]           shift_cnt, shift_cnt_next;
	scc_go_t                    scan_go;   // Target of the running scan
	logic [DQS_N-1:0]           dqs_shift;
	logic [IO_N-1:0]            io_shift;
	logic [ENA_W-1:0]           ena_decode, ena_mask;
	logic                       data_c, upd_c;
	logic [`SCC_DQS_GROUPS-1:0] dqs_ena_c, dqs_io_ena_c;
	logic [`SCC_DQ_PINS-1:0]    dq_ena_c;
	logic [`SCC_DM_PINS-1:0]    dm_ena_c;

	// FF selects every line, out of range shifts past the top and selects none
	assign ena_decode = (group_sel == 8'hFF) ? '1 : (ENA_W'(1) << group_sel);

	always_comb
	begin
		state_next     = state;
		shift_cnt_next = shift_cnt;
		scan_done      = 1'b0;
		data_c         = 1'b0;
		upd_c          = 1'b0;
		dqs_ena_c      = '0;
		dqs_io_ena_c   = '0;
		dq_ena_c       = '0;
		dm_ena_c       = '0;

		case (state)
			IDLE:
			begin
				if (go.dqs_io || go.dq || go.dm)
				begin
					state_next     = LOAD;
					shift_cnt_next = CNT_W'(IO_N - 1);
				end
				else if (go.dqs)
				begin
					state_next     = LOAD;
					shift_cnt_next = CNT_W'(DQS_N - 1);
				end
				else if (go.upd)
				begin
					state_next = DONE;
					upd_c      = 1'b1;
				end
			end
			LOAD:
			begin
				shift_cnt_next = shift_cnt - 1'b1;
				data_c         = scan_go.dqs ? dqs_shift[DQS_N-1] : io_shift[IO_N-1];
				if (scan_go.dqs)
					dqs_ena_c = ena_mask[`SCC_DQS_GROUPS-1:0];
				if (scan_go.dqs_io)
					dqs_io_ena_c = ena_mask[`SCC_DQS_GROUPS-1:0];
				if (scan_go.dq)
					dq_ena_c = ena_mask[`SCC_DQ_PINS-1:0];
				if (scan_go.dm)
					dm_ena_c = ena_mask[`SCC_DM_PINS-1:0];
				if (shift_cnt == '0)
					state_next = DONE;
			end
			DONE:
			begin
				scan_done = 1'b1;
				if (go == '0)   // Wait for the bus to drop the request
					state_next = IDLE;
			end
			default: state_next = IDLE;
		endcase
	end

	// Shift registers follow the staged words until a scan starts
	always_ff @(posedge avl_clk)
	begin
		if (state == IDLE)
		begin
			dqs_shift <= dqs_cfg;
			io_shift  <= io_cfg;
			ena_mask  <= ena_decode;
		end
		else if (state == LOAD)
		begin
			dqs_shift <= dqs_shift << 1;
			io_shift  <= io_shift << 1;
		end
	end

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			state          <= IDLE;
			shift_cnt      <= '0;
			scan_go        <= '0;
			scc_data       <= 1'b0;
			scc_dqs_ena    <= '0;
			scc_dqs_io_ena <= '0;
			scc_dq_ena     <= '0;
			scc_dm_ena     <= '0;
			scc_upd        <= 1'b0;
		end
		else
		begin
			state     <= state_next;
			shift_cnt <= shift_cnt_next;
			if (state == IDLE)
				scan_go <= '{dqs: go.dqs, dqs_io: go.dqs_io, dq: go.dq, dm: go.dm, upd: 1'b0};
			scc_data       <= data_c;   // One cycle behind LOAD
			scc_dqs_ena    <= dqs_ena_c;
			scc_dqs_io_ena <= dqs_io_ena_c;
			scc_dq_ena     <= dq_ena_c;
			scc_dm_ena     <= dm_ena_c;
			scc_upd        <= upd_c;
		end
	end

endmodule

`default_nettype wire

// ==== src/scc_cfg_regs.sv ====
/*
 * Staged DQS and I/O scan words
 * Power-up defaults and per-field SDATA updates
 */
`timescale 1ns/1ps
`default_nettype none
`include "scc_config.svh"

module scc_cfg_regs
	import scc_pkg::*;
(
	input  logic                           avl_clk,
	input  logic                           avl_reset_n,
	input  logic                           sdata_wr,
	input  scc_field_e                     field,
	input  logic [`SCC_AVL_DATA_WIDTH-1:0] avl_writedata,
	input  scc_phase_t                     phase,
	input  scc_phase_t                     phase_reset,
	input  logic [2:0]                     dqsi_phase,
	output scc_dqs_cfg_t                   dqs_cfg,
	output scc_io_cfg_t                    io_cfg
);

	scc_dqs_cfg_t dqs_reset_word;
	scc_dqs_cfg_t dqs_next;
	scc_io_cfg_t  io_next;

	// DQS and DQ output phase bits are spread over the word
	function automatic scc_dqs_cfg_t put_out_phase(scc_dqs_cfg_t cfg, scc_phase_t ph);
		cfg.dqs_ph_hi = ph.dqs[6:3];
		cfg.dqs_ph2   = ph.dqs[2];
		cfg.dqs_ph1   = ph.dqs[1];
		cfg.dqs_ph0   = ph.dqs[0];
		cfg.dq_ph_hi  = ph.dq[6:3];
		cfg.dq_ph2    = ph.dq[2];
		cfg.dq_ph1    = ph.dq[1];
		cfg.dq_ph0    = ph.dq[0];
		return cfg;
	endfunction

	function automatic scc_dqs_cfg_t put_en_phase(scc_dqs_cfg_t cfg, scc_phase_t ph);
		cfg.dqse_ph_hi = ph.dqse[5:2];
		cfg.dqse_ph1   = ph.dqse[1];
		cfg.dqse_ph0   = ph.dqse[0];
		return cfg;
	endfunction

	always_comb
	begin
		dqs_reset_word              = '0; // Zero delays
		dqs_reset_word.dqs_in_phase = dqsi_phase;
		dqs_reset_word              = put_out_phase(dqs_reset_word, phase_reset);
		dqs_reset_word              = put_en_phase(dqs_reset_word, phase_reset);
	end

	always_comb
	begin
		dqs_next = dqs_cfg;
		io_next  = io_cfg;

		// Fixed fields
		dqs_next.pad_42       = '0;
		dqs_next.pad_37       = 1'b0;
		dqs_next.pad_25       = 1'b0;
		dqs_next.pad_23       = '0;
		dqs_next.dqs_in_phase = dqsi_phase;

		if (sdata_wr)
		begin
			case (field)
				DQS_IN_DELAY:    dqs_next.dqs_in_delay = avl_writedata[3:0];
				DQS_EN_PHASE:    dqs_next = put_en_phase(dqs_next, phase);
				DQS_EN_DELAY:    dqs_next.dqs_en_delay = avl_writedata[2:0];
				DQDQS_OUT_PHASE: dqs_next = put_out_phase(dqs_next, phase);
				OCT_OUT1_DELAY:  dqs_next.oct_out1 = avl_writedata[3:0];
				OCT_OUT2_DELAY:  dqs_next.oct_out2 = avl_writedata[2:0];
				IO_OUT1_DELAY:   io_next.out1_delay = avl_writedata[3:0];
				IO_OUT2_DELAY:   io_next.out2_delay = avl_writedata[2:0];
				IO_IN_DELAY:     io_next.in_delay = avl_writedata[3:0];
				default:         io_next = io_cfg; // Unknown field, no change
			endcase
		end
	end

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			dqs_cfg <= dqs_reset_word;
			io_cfg  <= '0;
		end
		else
		begin
			dqs_cfg <= dqs_next;
			io_cfg  <= io_next;
		end
	end

endmodule

`default_nettype wire

// ==== src/scc_avl_slave.sv ====
/*
 * Avalon-MM slave of the scan-chain manager
 * Opcode decode, go requests, waitrequest and parameter read-back
 */
`timescale 1ns/1ps
`default_nettype none
`include "scc_config.svh"

module scc_avl_slave
	import scc_pkg::*;
(
	input  logic                           avl_clk,
	input  logic                           avl_reset_n,
	input  logic [`SCC_AVL_ADDR_WIDTH-1:0] avl_address,
	input  logic                           avl_write,
	input  logic                           avl_read,
	output logic [`SCC_AVL_DATA_WIDTH-1:0] avl_readdata,
	output logic                           avl_waitrequest,
	input  logic                           scan_done,
	output scc_go_t                        go,
	output logic                           sdata_wr,
	output scc_field_e                     field
);

	localparam int AW = `SCC_AVL_ADDR_WIDTH;

	logic        sel;
	scc_target_e opcode;
	scc_go_t     go_dec;
	logic        done_seen; // A GO completed and the engine has not left DONE yet

	assign sel    = (avl_address[AW-1 -: 3] == 3'b011);
	assign opcode = scc_target_e'(avl_address[AW-4 -: 3]);
	assign field  = scc_field_e'(avl_address[3:0]);

	always_comb
	begin
		go_dec   = '0;
		sdata_wr = 1'b0;
		if (sel && avl_write)
		begin
			case (opcode)
				SDATA:     sdata_wr      = 1'b1;
				GO_DQS:    go_dec.dqs    = 1'b1;
				GO_DQS_IO: go_dec.dqs_io = 1'b1;
				GO_DQ:     go_dec.dq     = 1'b1;
				GO_DM:     go_dec.dm     = 1'b1;
				GO_UPD:    go_dec.upd    = 1'b1;
				default:   go_dec        = '0;
			endcase
		end
	end

	// A back-to-back GO is held off until the engine is back in IDLE
	assign go              = done_seen ? '0 : go_dec;
	assign avl_waitrequest = (|go_dec) && (!scan_done || done_seen);

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
			done_seen <= 1'b0;
		else if (done_seen)
			done_seen <= scan_done;               // Clears once DONE is left
		else
			done_seen <= (|go_dec) && scan_done;  // GO accepted this cycle
	end

	// Read-back, zero for unknown codes
	always_comb
	begin
		avl_readdata = '0;
		if (sel && avl_read)
		begin
			case (scc_param_e'(avl_address[3:0]))
				PAR_DQS_IN_DELAY_MAX:     avl_readdata = 15;
				PAR_DQS_EN_PHASE_MAX:     avl_readdata = `SCC_DLL_CHAIN_LENGTH - 1;
				PAR_DQS_EN_DELAY_MAX:     avl_readdata = 7;
				PAR_DQDQS_OUT_PHASE_MAX:  avl_readdata = 2 * `SCC_DLL_CHAIN_LENGTH - 2;
				PAR_IO_OUT1_DELAY_MAX:    avl_readdata = 15;
				PAR_IO_OUT2_DELAY_MAX:    avl_readdata = 7;
				PAR_IO_IN_DELAY_MAX:      avl_readdata = 15;
				PAR_DLL_CHAIN_LENGTH:     avl_readdata = `SCC_DLL_CHAIN_LENGTH;
				PAR_DELAY_PER_OPA_TAP:    avl_readdata = `SCC_DELAY_PER_OPA_TAP;
				PAR_DELAY_PER_DCHAIN_TAP: avl_readdata = `SCC_DELAY_PER_DCHAIN_TAP;
				PAR_DQS_IN_RESERVE:       avl_readdata = 3;
				PAR_DQS_OUT_RESERVE:      avl_readdata = 3;
				PAR_DQ_OUT_RESERVE:       avl_readdata = 0;
				PAR_DM_OUT_RESERVE:       avl_readdata = 0;
				default:                  avl_readdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/scc_phase_decode.sv ====
/*
 * Phase code table for the 8-tap DLL
 * Reset, indexed and DQS-in phase codes
 */
`timescale 1ns/1ps
`default_nettype none

module scc_phase_decode
	import scc_pkg::*;
(
	input  logic [4:0] phase_index,
	output scc_phase_t phase,
	output scc_phase_t phase_reset,
	output logic [2:0] dqsi_phase
);

	// DQS-in sits at 90 deg
	assign dqsi_phase = 3'b001;

	// Power-up codes: DQS 540, DQ 450, DQSE 270 deg
	assign phase_reset = '{dqs: 7'b0010101, dq: 7'b0000110, dqse: 6'b001010};

	always_comb
	begin
		phase = '{dqs: 7'b0010100, dq: 7'b0000100, dqse: 6'b001000}; // Base codes

		case (phase_index)
			5'd1:
			begin
				phase = '{dqs: 7'b0011100, dq: 7'b0001100, dqse: 6'b001100};
			end
			5'd2:
			begin
				phase = '{dqs: 7'b0100100, dq: 7'b0010100, dqse: 6'b010000};
			end
			5'd3:
			begin
				phase = '{dqs: 7'b0101110, dq: 7'b0011100, dqse: 6'b000110};
			end
			5'd4:
			begin
				phase = '{dqs: 7'b0010010, dq: 7'b0000000, dqse: 6'b001010};
			end
			5'd5:
			begin
				phase = '{dqs: 7'b0011010, dq: 7'b0001010, dqse: 6'b001111};
			end
			5'd6:
			begin
				phase = '{dqs: 7'b0100010, dq: 7'b0010010, dqse: 6'b010011};
			end
			5'd7:
			begin
				phase = '{dqs: 7'b0101001, dq: 7'b0011010, dqse: 6'b000101};
			end
			// From here on DQSE keeps its base code
			5'd8:    {phase.dqs, phase.dq} = {7'b0010101, 7'b0000110}; // 540 / 450
			5'd9:    {phase.dqs, phase.dq} = {7'b0011101, 7'b0001101};
			5'd10:   {phase.dqs, phase.dq} = {7'b0100101, 7'b0010101};
			5'd11:   {phase.dqs, phase.dq} = {7'b0101111, 7'b0011101};
			5'd12:   {phase.dqs, phase.dq} = {7'b0010011, 7'b0000001}; // 720 / 630
			5'd13:   {phase.dqs, phase.dq} = {7'b0011011, 7'b0001011};
			5'd14:   {phase.dqs, phase.dq} = {7'b0100011, 7'b0010011};
			default: phase.dqse = 6'b001000; // Index 0 and out of range
		endcase
	end

endmodule

`default_nettype wire

// ==== src/scc_pkg.sv ====
/*
 * Shared types of the scan-chain manager
 * Opcode, field, parameter and state enums, phase codes,
 * staged DQS and I/O words and the go request bundle
 */
`default_nettype none

package scc_pkg;

	// Write opcode in address bits 12:10
	typedef enum logic [2:0] {
		SDATA     = 3'b000,
		GO_DQS    = 3'b001,
		GO_DQS_IO = 3'b010,
		GO_DQ     = 3'b011,
		GO_DM     = 3'b100,
		GO_UPD    = 3'b101
	} scc_target_e;

	// Field written by an SDATA access, address bits 3:0
	typedef enum logic [3:0] {
		DQS_IN_DELAY    = 4'b0001,
		DQS_EN_PHASE    = 4'b0010,
		DQS_EN_DELAY    = 4'b0011,
		DQDQS_OUT_PHASE = 4'b0100,
		OCT_OUT1_DELAY  = 4'b0110,
		OCT_OUT2_DELAY  = 4'b0111,
		IO_OUT1_DELAY   = 4'b1000,
		IO_OUT2_DELAY   = 4'b1001,
		IO_IN_DELAY     = 4'b1010
	} scc_field_e;

	// Read-back parameter, address bits 3:0
	typedef enum logic [3:0] {
		PAR_DQS_IN_DELAY_MAX     = 4'b0001,
		PAR_DQS_EN_PHASE_MAX     = 4'b0010,
		PAR_DQS_EN_DELAY_MAX     = 4'b0011,
		PAR_DQDQS_OUT_PHASE_MAX  = 4'b0100,
		PAR_IO_OUT1_DELAY_MAX    = 4'b0110,
		PAR_IO_OUT2_DELAY_MAX    = 4'b0111,
		PAR_IO_IN_DELAY_MAX      = 4'b1000,
		PAR_DLL_CHAIN_LENGTH     = 4'b1001,
		PAR_DELAY_PER_OPA_TAP    = 4'b1010,
		PAR_DQS_IN_RESERVE       = 4'b1011,
		PAR_DQS_OUT_RESERVE      = 4'b1100,
		PAR_DELAY_PER_DCHAIN_TAP = 4'b1101,
		PAR_DQ_OUT_RESERVE       = 4'b1110,
		PAR_DM_OUT_RESERVE       = 4'b1111
	} scc_param_e;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		DONE
	} scc_state_e;

	typedef struct packed {
		logic [6:0] dqs;
		logic [6:0] dq;
		logic [5:0] dqse;
	} scc_phase_t;

	// DQS scan word, MSB is shifted out first
	typedef struct packed {
		logic       dqs_ph2;      // 45
		logic       dq_ph2;
		logic       dqse_ph1;
		logic [1:0] pad_42;       // 42:41
		logic       dq_ph1;       // 40
		logic       dqs_ph1;
		logic       dqse_ph0;
		logic       pad_37;
		logic [2:0] oct_out2;     // 36:34
		logic [3:0] oct_out1;     // 33:30
		logic [2:0] dqs_en_delay; // 29:27
		logic       dq_ph0;       // 26
		logic       pad_25;
		logic       dqs_ph0;      // 24
		logic [4:0] pad_23;       // 23:19
		logic [3:0] dq_ph_hi;     // DQ phase 6:3
		logic [3:0] dqs_ph_hi;    // DQS phase 6:3
		logic [3:0] dqse_ph_hi;   // DQSE phase 5:2
		logic [2:0] dqs_in_phase;
		logic [3:0] dqs_in_delay;
	} scc_dqs_cfg_t;

	typedef struct packed {
		logic [3:0] in_delay;
		logic [2:0] out2_delay;
		logic [3:0] out1_delay;
	} scc_io_cfg_t;

	// One request line per GO opcode
	typedef struct packed {
		logic dqs;
		logic dqs_io;
		logic dq;
		logic dm;
		logic upd;
	} scc_go_t;

endpackage

`default_nettype wire

// ==== include/scc_config.svh ====
/*
 * Build-time constants for the scan-chain configuration manager
 * Avalon bus widths, enable line counts, DLL chain length,
 * read-back tap delays and scan word lengths
 */
`ifndef SCC_CONFIG_SVH
`define SCC_CONFIG_SVH

// Avalon-MM slave port
`define SCC_AVL_ADDR_WIDTH 16
`define SCC_AVL_DATA_WIDTH 32

// Enable lines per scan target
`define SCC_DQS_GROUPS 2
`define SCC_DQ_PINS    16
`define SCC_DM_PINS    2

`define SCC_DLL_CHAIN_LENGTH 8

// Tap delays in ps, read back by software only
`define SCC_DELAY_PER_OPA_TAP    312
`define SCC_DELAY_PER_DCHAIN_TAP 25

`define SCC_DQS_SDATA_BITS 46 // DQS scan word
`define SCC_IO_SDATA_BITS  11 // DQ, DM and DQS-I/O scan word

`endif
